// File: Makefile
VERILATOR ?= verilator
FILELIST ?= sim.f
TB_TOP ?= tb_lcd_panel
RTL_TOP ?= lcd_panel_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/lcd_panel_pkg.sv
package lcd_panel_pkg;

	localparam logic [7:0] BUTTON_TAG = 8'h42;

	typedef enum logic [2:0] {
		NONE,
		RUN,
		OFF,
		SWEEP,
		LOCK
	} button_t;

	// Soft buttons share one column
	localparam logic [15:0] BTN_X_LO = 16'd75;
	localparam logic [15:0] BTN_X_HI = 16'd210;
	localparam logic [15:0] RUN_X_LO = 16'd84;	// RUN is a little narrower

	// Index 0 is RUN, then OFF, SWEEP, LOCK
	localparam logic [3:0][15:0] BTN_Y_LO = {16'd84, 16'd312, 16'd545, 16'd768};
	localparam logic [3:0][15:0] BTN_Y_HI = {16'd187, 16'd415, 16'd643, 16'd871};

	localparam int FREQ_KEYS = 11;

	// Key k selects 29+k kHz and key 0 is the rightmost entry
	localparam logic [FREQ_KEYS-1:0][15:0] FREQ_X_LO = {
		16'd909, 16'd848, 16'd791, 16'd736, 16'd670, 16'd616,
		16'd553, 16'd492, 16'd432, 16'd372, 16'd311
	};
	localparam logic [FREQ_KEYS-1:0][15:0] FREQ_X_HI = {
		16'd940, 16'd880, 16'd816, 16'd768, 16'd707, 16'd652,
		16'd587, 16'd523, 16'd468, 16'd412, 16'd348
	};

	typedef struct packed {
		logic [7:0] tag;
		logic [15:0] x;
		logic [15:0] y;
	} touch_point_t;

	typedef struct packed {
		logic run;
		logic off;
		logic sweep;
		logic lock;
		logic [3:0] freq_cho;	// 0 when no key is chosen
	} panel_ctrl_t;

endpackage

// File: common/lcd_spi_pkg.sv
package lcd_spi_pkg;

	localparam int MAX_BITS = 64;
	localparam int TOUCH_CAPTURE_BITS = 40;	// Tag, Y, X at the end of a read
	localparam int FIRST_TOUCH_STEP = 15;	// Table steps before the touch reads

	typedef enum logic [1:0] {
		HOST_CMD,
		REG_WRITE,
		TOUCH_READ
	} spi_op_t;

	typedef struct packed {
		spi_op_t op;
		logic [6:0] len;	// Bits in the transaction
		logic [MAX_BITS-1:0] payload;	// Left aligned, sent MSB first
	} spi_cmd_t;

	localparam logic [6:0] LEN_HOST_CMD = 7'd24;
	localparam logic [6:0] LEN_REG_SHORT = 7'd32;
	localparam logic [6:0] LEN_REG_LONG = 7'd40;
	localparam logic [6:0] LEN_TOUCH = 7'd64;

	localparam logic [23:0] CMD_ACTIVE = 24'h000000;
	localparam logic [23:0] CMD_CLKEXT = 24'h614500;

	// Write addresses already carry the write flag in the top byte
	localparam logic [23:0] REG_HCYCLE = 24'hB0202C;
	localparam logic [23:0] REG_HOFFSET = 24'hB02030;
	localparam logic [23:0] REG_HSYNC1 = 24'hB0203C;
	localparam logic [23:0] REG_VCYCLE = 24'hB02040;
	localparam logic [23:0] REG_VOFFSET = 24'hB02044;
	localparam logic [23:0] REG_PCLK = 24'hB02070;
	localparam logic [23:0] REG_DLSWAP = 24'hB02054;
	localparam logic [23:0] TOUCH_ADDR = 24'h302124;	// Read of tag and screen XY

	// Colour words in the display list with RUN at index 0
	localparam logic [3:0][23:0] BTN_COLOR_ADDR = {24'hB00120, 24'hB00110, 24'hB00100, 24'hB000F0};
	localparam logic [23:0] FREQ_COLOR_ADDR = 24'hB0020C;

	localparam logic [7:0] COLOR_ON = 8'h00;
	localparam logic [7:0] COLOR_OFF = 8'hFF;

endpackage

// File: logic/command_table.sv
`timescale 1ns/1ps

module command_table #(
	parameter int TOUCH_READS = 6
) (
	input  logic [$clog2(lcd_spi_pkg::FIRST_TOUCH_STEP+TOUCH_READS)-1:0] step,
	input  lcd_panel_pkg::button_t last_button,
	input  logic [3:0] freq_key,
	output lcd_spi_pkg::spi_cmd_t cmd
);

	// Table words are written right aligned and moved to the top here
	function automatic lcd_spi_pkg::spi_cmd_t make_cmd(input lcd_spi_pkg::spi_op_t op,
			input logic [6:0] len, input logic [63:0] word);
		lcd_spi_pkg::spi_cmd_t c;
		c.op = op;
		c.len = len;
		c.payload = word << (lcd_spi_pkg::MAX_BITS - int'(len));
		return c;
	endfunction

	logic [1:0] btn_idx;
	logic [7:0] btn_color;
	logic [7:0] key_color;

	assign btn_idx = 2'(step - 9);	// Button writes start at step 9
	assign btn_color = (last_button == lcd_panel_pkg::button_t'(btn_idx + 3'd1)) ?
		lcd_spi_pkg::COLOR_ON : lcd_spi_pkg::COLOR_OFF;
	assign key_color = (freq_key != 4'd0) ? lcd_spi_pkg::COLOR_ON : lcd_spi_pkg::COLOR_OFF;

	always_comb begin
		case (step)
			0, 1: cmd = make_cmd(lcd_spi_pkg::HOST_CMD, lcd_spi_pkg::LEN_HOST_CMD,
				64'(lcd_spi_pkg::CMD_ACTIVE));
			2: cmd = make_cmd(lcd_spi_pkg::HOST_CMD, lcd_spi_pkg::LEN_HOST_CMD,
				64'(lcd_spi_pkg::CMD_CLKEXT));
			3: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::REG_HCYCLE, 16'hA003}));
			4: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::REG_HOFFSET, 16'h5800}));
			5: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::REG_HSYNC1, 16'h3000}));
			6: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::REG_VCYCLE, 16'h0D02}));
			7: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::REG_VOFFSET, 16'h2000}));
			8: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_SHORT,
				64'({lcd_spi_pkg::REG_PCLK, 8'h02}));
			9, 10, 11, 12: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_SHORT,
				64'({lcd_spi_pkg::BTN_COLOR_ADDR[btn_idx], btn_color}));
			13: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_LONG,
				64'({lcd_spi_pkg::FREQ_COLOR_ADDR, 4'h0, freq_key, key_color}));
			14: cmd = make_cmd(lcd_spi_pkg::REG_WRITE, lcd_spi_pkg::LEN_REG_SHORT,
				64'({lcd_spi_pkg::REG_DLSWAP, 8'h02}));	// Show the new frame
			default: cmd = make_cmd(lcd_spi_pkg::TOUCH_READ, lcd_spi_pkg::LEN_TOUCH,
				{lcd_spi_pkg::TOUCH_ADDR, 40'h0});
		endcase
	end

endmodule

// File: logic/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int SCLK_DIV = 2,
	parameter int CS_GAP = 2,
	parameter int TOUCH_READS = 6
) (
	input  logic clk20MHz,
	input  logic rst_n,
	input  lcd_spi_pkg::spi_cmd_t cmd,
	input  logic done,
	input  logic [lcd_spi_pkg::TOUCH_CAPTURE_BITS-1:0] capture,
	output logic [$clog2(lcd_spi_pkg::FIRST_TOUCH_STEP+TOUCH_READS)-1:0] step,
	output logic start,
	output logic touch_valid,
	output lcd_panel_pkg::touch_point_t touch
);

	localparam int STEPS = lcd_spi_pkg::FIRST_TOUCH_STEP + TOUCH_READS;
	localparam int STEP_W = $clog2(STEPS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(STEPS - 1);
	localparam int GAP_CYC = CS_GAP * 2 * SCLK_DIV;	// cs_n high time in clocks
	localparam int GAP_W = $clog2(GAP_CYC + 1);

	typedef enum logic [1:0] {
		LAUNCH,
		WAIT_DONE,
		GAP
	} state_t;

	state_t state;
	logic [GAP_W-1:0] gap_cnt;

	assign start = (state == LAUNCH);
	assign touch_valid = done && (cmd.op == lcd_spi_pkg::TOUCH_READ);

	// Panel sends X and Y low byte first
	assign touch.tag = capture[39:32];
	assign touch.y = {capture[23:16], capture[31:24]};
	assign touch.x = {capture[7:0], capture[15:8]};

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			state <= LAUNCH;
			step <= '0;
			gap_cnt <= '0;
		end else begin
			case (state)
				LAUNCH: state <= WAIT_DONE;
				WAIT_DONE: begin
					if (done) begin
						step <= (step == LAST_STEP) ? '0 : step + STEP_W'(1);	// Endless frames
						gap_cnt <= GAP_W'(GAP_CYC - 2);	// Done and launch cycles count too
						state <= (GAP_CYC > 2) ? GAP : LAUNCH;
					end
				end
				GAP: begin
					gap_cnt <= gap_cnt - GAP_W'(1);
					if (gap_cnt == GAP_W'(1))
						state <= LAUNCH;
				end
				default: state <= LAUNCH;
			endcase
		end
	end

endmodule

// File: logic/lcd_panel_top.sv
`timescale 1ns/1ps

module lcd_panel_top #(
	parameter int SCLK_DIV = 2,
	parameter int CS_GAP = 2,
	parameter int TOUCH_READS = 6
) (
	input  logic clk20MHz,
	input  logic rst_n,
	input  logic miso,
	output logic sclk,
	output logic mosi,
	output logic cs_n,
	output lcd_panel_pkg::panel_ctrl_t ctrl
);

	localparam int STEP_W = $clog2(lcd_spi_pkg::FIRST_TOUCH_STEP + TOUCH_READS);

	logic [STEP_W-1:0] step;
	lcd_spi_pkg::spi_cmd_t cmd;
	logic start;
	logic done;
	logic [lcd_spi_pkg::TOUCH_CAPTURE_BITS-1:0] capture;
	logic touch_valid;
	lcd_panel_pkg::touch_point_t touch;
	lcd_panel_pkg::button_t last_button;
	logic [3:0] freq_key;

	frame_sequencer #(
		.SCLK_DIV(SCLK_DIV),
		.CS_GAP(CS_GAP),
		.TOUCH_READS(TOUCH_READS)
	) u_frame_sequencer (
		.clk20MHz(clk20MHz),
		.rst_n(rst_n),
		.cmd(cmd),
		.done(done),
		.capture(capture),
		.step(step),
		.start(start),
		.touch_valid(touch_valid),
		.touch(touch)
	);

	command_table #(
		.TOUCH_READS(TOUCH_READS)
	) u_command_table (
		.step(step),
		.last_button(last_button),
		.freq_key(freq_key),
		.cmd(cmd)
	);

	spi_shifter #(
		.SCLK_DIV(SCLK_DIV)
	) u_spi_shifter (
		.clk20MHz(clk20MHz),
		.rst_n(rst_n),
		.start(start),
		.cmd(cmd),
		.miso(miso),
		.sclk(sclk),
		.mosi(mosi),
		.cs_n(cs_n),
		.done(done),
		.capture(capture)
	);

	touch_decoder u_touch_decoder (
		.clk20MHz(clk20MHz),
		.rst_n(rst_n),
		.touch_valid(touch_valid),
		.touch(touch),
		.ctrl(ctrl),
		.last_button(last_button),
		.freq_key(freq_key)
	);

endmodule

// File: logic/touch_decoder.sv
`timescale 1ns/1ps

module touch_decoder (
	input  logic clk20MHz,
	input  logic rst_n,
	input  logic touch_valid,
	input  lcd_panel_pkg::touch_point_t touch,
	output lcd_panel_pkg::panel_ctrl_t ctrl,
	output lcd_panel_pkg::button_t last_button,
	output logic [3:0] freq_key
);

	function automatic logic in_range(input logic [15:0] v, input logic [15:0] lo,
			input logic [15:0] hi);
		return (v >= lo) && (v <= hi);
	endfunction

	lcd_panel_pkg::button_t hit_btn;
	logic [3:0] hit_key;
	logic [15:0] x_lo;

	// First match wins with buttons tested before keys
	always_comb begin
		hit_btn = lcd_panel_pkg::NONE;
		hit_key = 4'd0;
		x_lo = lcd_panel_pkg::BTN_X_LO;
		if (touch.tag == lcd_panel_pkg::BUTTON_TAG) begin
			for (int b = 0; b < 4; b++) begin
				x_lo = (b == 0) ? lcd_panel_pkg::RUN_X_LO : lcd_panel_pkg::BTN_X_LO;
				if (hit_btn == lcd_panel_pkg::NONE
						&& in_range(touch.x, x_lo, lcd_panel_pkg::BTN_X_HI)
						&& in_range(touch.y, lcd_panel_pkg::BTN_Y_LO[b], lcd_panel_pkg::BTN_Y_HI[b]))
					hit_btn = lcd_panel_pkg::button_t'(3'(b + 1));
			end
			for (int k = 0; k < lcd_panel_pkg::FREQ_KEYS; k++) begin
				if (hit_btn == lcd_panel_pkg::NONE && hit_key == 4'd0
						&& in_range(touch.x, lcd_panel_pkg::FREQ_X_LO[k],
						lcd_panel_pkg::FREQ_X_HI[k]))
					hit_key = 4'(k + 1);	// Keys span the full height so only X matters
			end
		end
	end

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
			last_button <= lcd_panel_pkg::NONE;
			freq_key <= 4'd0;
		end else if (touch_valid) begin
			ctrl.run <= (hit_btn == lcd_panel_pkg::RUN);
			ctrl.off <= (hit_btn == lcd_panel_pkg::OFF);
			ctrl.sweep <= (hit_btn == lcd_panel_pkg::SWEEP);
			ctrl.lock <= (hit_btn == lcd_panel_pkg::LOCK);
			ctrl.freq_cho <= hit_key;	// Miss gives all zero
			if (hit_btn != lcd_panel_pkg::NONE)
				last_button <= hit_btn;	// Held for the highlight colours
			if (hit_key != 4'd0)
				freq_key <= hit_key;
		end
	end

	// A touch selects at most one button or one key
	a_ctrl_exclusive: assert property (@(posedge clk20MHz) disable iff (!rst_n)
		$onehot0({ctrl.run, ctrl.off, ctrl.sweep, ctrl.lock, |ctrl.freq_cho}));

endmodule

// File: sim.f
common/lcd_spi_pkg.sv
common/lcd_panel_pkg.sv
spi/spi_shifter.sv
logic/frame_sequencer.sv
logic/command_table.sv
logic/touch_decoder.sv
logic/lcd_panel_top.sv
verif/tb_lcd_panel.sv

// File: spi/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
	parameter int SCLK_DIV = 2
) (
	input  logic clk20MHz,
	input  logic rst_n,
	input  logic start,
	input  lcd_spi_pkg::spi_cmd_t cmd,
	input  logic miso,
	output logic sclk,
	output logic mosi,
	output logic cs_n,
	output logic done,
	output logic [lcd_spi_pkg::TOUCH_CAPTURE_BITS-1:0] capture
);

	localparam int DIV_W = $clog2(SCLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);
	localparam int CAP_W = lcd_spi_pkg::TOUCH_CAPTURE_BITS;
	localparam int MSB = lcd_spi_pkg::MAX_BITS - 1;

	logic busy;
	logic [DIV_W-1:0] div_cnt;
	logic [6:0] bits_left;
	logic [lcd_spi_pkg::MAX_BITS-1:0] shreg;
	logic half_tick;
	logic launch;

	assign launch = start && !busy;
	assign half_tick = busy && (div_cnt == DIV_LAST);	// End of one sclk phase

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cs_n <= 1'b1;
			sclk <= 1'b0;
			mosi <= 1'b0;
			done <= 1'b0;
			div_cnt <= '0;
			bits_left <= '0;
		end else begin
			done <= 1'b0;
			if (launch) begin
				busy <= 1'b1;
				cs_n <= 1'b0;
				sclk <= 1'b0;
				div_cnt <= '0;
				bits_left <= cmd.len;
				mosi <= cmd.payload[MSB];	// First bit ready before the first rise
			end else if (busy) begin
				div_cnt <= half_tick ? '0 : div_cnt + DIV_W'(1);
				if (half_tick) begin
					sclk <= ~sclk;
					if (sclk) begin	// Falling edge closes a bit
						bits_left <= bits_left - 7'd1;
						if (bits_left == 7'd1) begin
							busy <= 1'b0;
							cs_n <= 1'b1;
							done <= 1'b1;
							mosi <= 1'b0;
						end else begin
							mosi <= shreg[MSB];
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (launch)
			shreg <= cmd.payload << 1;
		else if (half_tick && sclk)
			shreg <= shreg << 1;
		if (half_tick && !sclk)
			capture <= {capture[CAP_W-2:0], miso};	// Sample as sclk rises
	end

	// The sequencer may only launch once the previous done has come back
	a_no_start_busy: assert property (@(posedge clk20MHz) disable iff (!rst_n)
		start |-> !busy);

	a_len_range: assert property (@(posedge clk20MHz) disable iff (!rst_n)
		start |-> (cmd.len != 7'd0 && cmd.len <= lcd_spi_pkg::MAX_BITS));

endmodule

// File: verif/lcd_stimulus.txt
# F step len payload: start-up frame, payload in hex right aligned, steps 9 to 13 follow the held state
# T tag(hex) x y run off sweep lock freq_cho last_button key, last_button 1 RUN 2 OFF 3 SWEEP 4 LOCK
F 0 24 000000
F 1 24 000000
F 2 24 614500
F 3 40 B0202CA003
F 4 40 B020305800
F 5 40 B0203C3000
F 6 40 B020400D02
F 7 40 B020442000
F 8 32 B0207002
F 14 32 B0205402
T 42 150 800 1 0 0 0 0 1 0
T 42 100 600 0 1 0 0 0 2 0
T 42 211 600 0 0 0 0 0 2 0
T 42 450 500 0 0 0 0 3 2 3
T 42 120 350 0 0 1 0 0 3 3
T 17 620 300 0 0 0 0 0 3 3
T 42 200 100 0 0 0 1 0 4 3
T 42 80 800 0 0 0 0 0 4 3
T 42 925 50 0 0 0 0 11 4 11
T 42 150 188 0 0 0 0 0 4 11

// File: verif/tb_lcd_panel.sv
`timescale 1ns/1ps

module tb_lcd_panel;

	localparam int SCLK_DIV = 2;	// DUT default bit rate
	localparam int TOUCH_READS = 6;
	localparam int TABLE_STEPS = 15;	// Steps before the touch reads
	localparam int MAX_TESTS = 32;

	logic clk20MHz;
	logic rst_n;
	logic miso;
	logic sclk;
	logic mosi;
	logic cs_n;
	lcd_panel_pkg::panel_ctrl_t ctrl;

	int frame_len [TABLE_STEPS];
	logic [63:0] frame_word [TABLE_STEPS];	// Right aligned
	logic [7:0] t_tag [MAX_TESTS];
	logic [15:0] t_x [MAX_TESTS];
	logic [15:0] t_y [MAX_TESTS];
	lcd_panel_pkg::panel_ctrl_t t_ctrl [MAX_TESTS];
	int t_btn [MAX_TESTS];
	int t_key [MAX_TESTS];
	int ntests;
	logic [7:0] cur_tag;	// Point the slave returns on a touch read
	logic [15:0] cur_x;
	logic [15:0] cur_y;
	int errors;
	int passed;
	int failed;
	logic aborted;

	lcd_panel_top u_lcd_panel_top (
		.clk20MHz(clk20MHz),
		.rst_n(rst_n),
		.miso(miso),
		.sclk(sclk),
		.mosi(mosi),
		.cs_n(cs_n),
		.ctrl(ctrl)
	);

	initial begin
		clk20MHz = 1'b0;
		forever #25 clk20MHz = ~clk20MHz;
	end

	task automatic compare_hex(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("Error: %s expected 0x%0h got 0x%0h", name, expected, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int prev_errors);
		if (errors == prev_errors && !aborted) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: failed with %0d errors", name, errors - prev_errors);
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int step;
		int len;
		int x;
		int y;
		int r;
		int o;
		int s;
		int l;
		int fq;
		int b;
		int k;
		logic [63:0] word;
		logic [7:0] tag;
		string line;
		fd = $fopen("verif/lcd_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/lcd_stimulus.txt");
			aborted = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			if (line[0] == "F" && $sscanf(line, "F %d %d %h", step, len, word) == 3) begin
				if (step >= 0 && step < TABLE_STEPS) begin
					frame_len[step] = len;
					frame_word[step] = word;
				end
			end else if (line[0] == "T" && ntests < MAX_TESTS) begin
				if ($sscanf(line, "T %h %d %d %d %d %d %d %d %d %d",
						tag, x, y, r, o, s, l, fq, b, k) == 10) begin
					t_tag[ntests] = tag;
					t_x[ntests] = 16'(x);
					t_y[ntests] = 16'(y);
					t_ctrl[ntests] = {1'(r), 1'(o), 1'(s), 1'(l), 4'(fq)};
					t_btn[ntests] = b;
					t_key[ntests] = k;
					ntests++;
				end
			end
		end
		$fclose(fd);
		if (ntests == 0) begin
			$display("No touch tests found in the stimulus file");
			aborted = 1'b1;
		end
	endtask

	// SPI slave model for one cs_n low window with mosi taken MSB first
	task automatic receive_transaction(output int nbits, output logic [63:0] word,
			output int low_cyc);
		int wait_cnt;
		logic sclk_q;
		logic is_touch;
		logic [39:0] reply;
		nbits = 0;
		word = '0;
		low_cyc = 0;
		wait_cnt = 0;
		sclk_q = 1'b0;
		is_touch = 1'b0;
		reply = {cur_tag, cur_y[7:0], cur_y[15:8], cur_x[7:0], cur_x[15:8]};	// Low byte first
		while (cs_n !== 1'b0 && wait_cnt < 100) begin
			@(posedge clk20MHz);
			#1;
			wait_cnt++;
		end
		if (cs_n !== 1'b0) begin
			$display("Timeout: cs_n did not fall within 100 cycles");
			aborted = 1'b1;
			return;
		end
		miso = 1'($urandom);
		wait_cnt = 0;
		while (cs_n === 1'b0 && wait_cnt < 400) begin
			low_cyc++;
			wait_cnt++;
			@(posedge clk20MHz);
			#1;
			if (sclk && !sclk_q) begin
				word = {word[62:0], mosi};	// Rising sclk
				nbits++;
			end else if (!sclk && sclk_q) begin
				if (nbits == 24 && word[23:0] == lcd_spi_pkg::TOUCH_ADDR)
					is_touch = 1'b1;
				miso = (is_touch && nbits < 64) ? reply[63 - nbits] : 1'($urandom);
			end
			sclk_q = sclk;
		end
		if (cs_n !== 1'b1) begin
			$display("Timeout: cs_n stayed low for 400 cycles");
			aborted = 1'b1;
		end
	endtask

	task automatic check_frame_setup(input int held_btn, input int held_key);
		int nbits;
		int low;
		int exp_len;
		logic [63:0] word;
		logic [63:0] exp_word;
		for (int s = 0; s < TABLE_STEPS && !aborted; s++) begin
			if (s >= 9 && s <= 12) begin
				exp_len = 32;
				exp_word = 64'({lcd_spi_pkg::BTN_COLOR_ADDR[s - 9],
					(held_btn == s - 8) ? lcd_spi_pkg::COLOR_ON : lcd_spi_pkg::COLOR_OFF});
			end else if (s == 13) begin
				exp_len = 40;
				exp_word = 64'({lcd_spi_pkg::FREQ_COLOR_ADDR, 4'h0, 4'(held_key),
					(held_key != 0) ? lcd_spi_pkg::COLOR_ON : lcd_spi_pkg::COLOR_OFF});
			end else begin
				exp_len = frame_len[s];
				exp_word = frame_word[s];
			end
			receive_transaction(nbits, word, low);
			if (!aborted) begin
				compare_hex($sformatf("step %0d length", s), 64'(nbits), 64'(exp_len));
				compare_hex($sformatf("step %0d mosi", s), word, exp_word);
				compare_hex($sformatf("step %0d cs_n low cycles", s), 64'(low),
					64'(exp_len * 2 * SCLK_DIV));
			end
		end
	endtask

	task automatic test_touch_reads(input int t);
		int nbits;
		int low;
		logic [63:0] word;
		cur_tag = t_tag[t];
		cur_x = t_x[t];
		cur_y = t_y[t];
		for (int r = 0; r < TOUCH_READS && !aborted; r++) begin
			receive_transaction(nbits, word, low);
			if (!aborted) begin
				compare_hex("touch read length", 64'(nbits), 64'd64);
				compare_hex("touch read address", 64'(word[63:40]), 64'(lcd_spi_pkg::TOUCH_ADDR));
				compare_hex("touch read cs_n low cycles", 64'(low), 64'(64 * 2 * SCLK_DIV));
				@(posedge clk20MHz);	// ctrl lands one cycle after done
				#1;
				compare_hex("ctrl.run", 64'(ctrl.run), 64'(t_ctrl[t].run));
				compare_hex("ctrl.off", 64'(ctrl.off), 64'(t_ctrl[t].off));
				compare_hex("ctrl.sweep", 64'(ctrl.sweep), 64'(t_ctrl[t].sweep));
				compare_hex("ctrl.lock", 64'(ctrl.lock), 64'(t_ctrl[t].lock));
				compare_hex("ctrl.freq_cho", 64'(ctrl.freq_cho), 64'(t_ctrl[t].freq_cho));
			end
		end
	endtask

	initial begin
		int prev_errors;
		int held_btn;
		int held_key;
		void'($urandom(33));
		rst_n = 1'b0;
		miso = 1'b0;
		cur_tag = '0;
		cur_x = '0;
		cur_y = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		ntests = 0;
		aborted = 1'b0;
		load_stimulus();
		repeat (4) @(posedge clk20MHz);
		#1;
		prev_errors = errors;
		compare_hex("cs_n", 64'(cs_n), 64'd1);
		compare_hex("sclk", 64'(sclk), 64'd0);
		compare_hex("mosi", 64'(mosi), 64'd0);
		compare_hex("ctrl", 64'(ctrl), 64'd0);
		report_test("reset state", prev_errors);
		rst_n = 1'b1;
		held_btn = 0;	// Nothing highlighted after reset
		held_key = 0;
		for (int f = 0; f <= ntests && !aborted; f++) begin
			prev_errors = errors;
			check_frame_setup(held_btn, held_key);
			if (f < ntests) begin
				test_touch_reads(f);
				report_test($sformatf("frame %0d tag 0x%02h x %0d y %0d", f, t_tag[f],
					t_x[f], t_y[f]), prev_errors);
				held_btn = t_btn[f];
				held_key = t_key[f];
			end else begin
				report_test($sformatf("frame %0d highlight", f), prev_errors);
			end
		end
		$display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (failed == 0 && errors == 0 && !aborted)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
